// ==== verilog.f ====
+incdir+rtl
rtl/hdmi_ctrl_pkg.sv
rtl/i2c_write_if.sv
rtl/startup_delay.sv
rtl/reconf_decoder.sv
rtl/adv_register_sequencer.sv
rtl/i2c_write_master.sv
rtl/dc_reset_hold.sv
rtl/hdmi_ctrl_top.sv
sim/tb_hdmi_ctrl.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_hdmi_ctrl
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== sim/tb_hdmi_ctrl.sv ====
`timescale 1ns/100ps
`include "hdmi_ctrl_cfg.svh"

module tb_hdmi_ctrl;

    logic       control_clock;
    logic       reset_dc_out;
    logic       video_ready;
    logic       rdempty;
    logic [7:0] fdata;
    logic       rdreq;
    logic       scl_oe;
    logic       sda_oe;
    logic       sda_in;
    logic       ready;
    logic       dc_nreset;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    logic [7:0]  fifo_q[$];
    logic        fifo_take;
    logic [23:0] got_q[$];
    logic [23:0] exp_q[$];
    logic [23:0] last_w[0:3];
    logic        compare_en = 1'b1;
    logic [9:0]  cfg_ref;
    logic [15:0] lfsr = 16'd11195;

    // slave model state
    logic        prev_scl = 1'b1;
    logic        prev_sda = 1'b1;
    logic        in_frame = 1'b0;
    int          bit_cnt;
    int          byte_cnt;
    logic [7:0]  shreg;
    logic [7:0]  rx_bytes[0:2];
    logic        ack_drive = 1'b0;
    logic        nack_arm = 1'b0;
    int          nack_byte;
    int          nack_start;
    int          start_count = 0;

    hdmi_ctrl_top hdmi_ctrl_top_inst (
        .control_clock (control_clock),
        .reset_dc_out  (reset_dc_out),
        .video_ready   (video_ready),
        .rdempty       (rdempty),
        .fdata         (fdata),
        .rdreq         (rdreq),
        .scl_oe        (scl_oe),
        .sda_oe        (sda_oe),
        .sda_in        (sda_in),
        .ready         (ready),
        .dc_nreset     (dc_nreset)
    );

    initial begin
        control_clock = 1'b0;
        forever #20 control_clock = !control_clock;
    end

    // slave pulls the open-drain sda low for the acknowledge
    assign sda_in = !(sda_oe || ack_drive);

    //////////////////////////////
    // fifo model
    // byte shows up on fdata one cycle after rdreq
    always @(posedge control_clock) begin
        fifo_take = rdreq;
        #2;
        if (fifo_take && (fifo_q.size() > 0)) begin
            fdata = fifo_q.pop_front();
        end
        rdempty = (fifo_q.size() == 0);
    end

    //////////////////////////////
    // i2c slave model
    always @(negedge control_clock) begin
        logic scl;
        logic sda;
        scl = !scl_oe;
        sda = sda_in;
        if (scl && prev_scl && prev_sda && !sda) begin
            in_frame    = 1'b1;
            bit_cnt     = 0;
            byte_cnt    = 0;
            start_count = start_count + 1;
        end else if (scl && prev_scl && !prev_sda && sda) begin
            if (in_frame && (byte_cnt == 3)) begin
                got_q.push_back({rx_bytes[0], rx_bytes[1], rx_bytes[2]});
                last_w[0] = last_w[1];
                last_w[1] = last_w[2];
                last_w[2] = last_w[3];
                last_w[3] = {rx_bytes[0], rx_bytes[1], rx_bytes[2]};
            end
            in_frame = 1'b0;
        end else if (in_frame && scl && !prev_scl) begin
            if (bit_cnt < 8) begin
                shreg   = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 1;
            end else begin
                if (byte_cnt < 3) begin
                    rx_bytes[byte_cnt] = shreg;
                end
                byte_cnt = byte_cnt + 1;
                bit_cnt  = 0;
            end
        end else if (in_frame && !scl && prev_scl) begin
            if ((bit_cnt == 8) && nack_arm && (start_count == nack_start)
                    && (byte_cnt == nack_byte)) begin
                nack_arm  = 1'b0;
                ack_drive = 1'b0;
            end else begin
                ack_drive = (bit_cnt == 8);
            end
        end
        prev_scl = scl;
        prev_sda = !(sda_oe || ack_drive);
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    // compare received writes against the expected queue
    always @(negedge control_clock) begin
        if (compare_en && (got_q.size() > 0) && (exp_q.size() > 0)) begin
            check_value("i2c_write", {8'd0, exp_q.pop_front()}, {8'd0, got_q.pop_front()});
        end
    end

    // decoder rule on a {color_space, pixel_repeat, vic} config
    function automatic logic [9:0] apply_byte(input logic [9:0] cfg, input logic [7:0] b);
        logic [9:0] next;
        next = cfg;
        if (!b[7]) begin
            next[6:0] = b[6:0];
        end else if (b[6:4] == 3'd0) begin
            next[9] = b[0];
        end else if (b[6:4] == 3'd1) begin
            next[8:7] = b[1:0];
        end
        return next;
    endfunction

    // one register write of the list per index
    function automatic logic [23:0] ref_write(input logic [9:0] cfg, input int idx);
        case (idx)
            0: return {`ADV_DEV_ADDR, `ADV_REG_POWER, `ADV_POWER_UP_VALUE};
            1: return {`ADV_DEV_ADDR, `ADV_REG_CSC, 7'd0, cfg[9]};
            2: return {`ADV_DEV_ADDR, `ADV_REG_REPEAT, 6'd0, cfg[8:7]};
            default: return {`ADV_DEV_ADDR, `ADV_REG_VIC, 1'b0, cfg[6:0]};
        endcase
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic expect_list(input logic [9:0] cfg);
        for (int i = 0; i < 4; i++) begin
            exp_q.push_back(ref_write(cfg, i));
        end
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        while (!ready && (n < 20000)) begin
            @(negedge control_clock);
            n = n + 1;
        end
        if (!ready) begin
            errors = errors + 1;
            $display("timeout: ready never rose during %s", what);
        end
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (((fifo_q.size() > 0) || (exp_q.size() > 0) || !rdempty) && (n < 20000)) begin
            @(negedge control_clock);
            n = n + 1;
        end
        if (n >= 20000) begin
            errors = errors + 1;
            $display("timeout: fifo or expected writes not drained during %s", what);
        end
    endtask

    task automatic settle(input int cycles);
        int n;
        n = 0;
        while (n < cycles) begin
            @(negedge control_clock);
            n = n + 1;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] next;
        int         starts;
        starts = start_count;
        next   = apply_byte(cfg_ref, b);
        fifo_q.push_back(b);
        if (next != cfg_ref) begin
            cfg_ref = next;
            expect_list(cfg_ref);
            settle(6);
            check_value("ready", 32'd0, {31'd0, ready});
            wait_ready("rewrite");
            check_value("writes_before_ready", 32'd0, exp_q.size());
            wait_drained("rewrite");
            settle(20);
            check_value("start_count", 32'd4, start_count - starts);
        end else begin
            wait_drained("ignored byte");
            settle(20);
            check_value("ready", 32'd1, {31'd0, ready});
            check_value("start_count", 32'd0, start_count - starts);
        end
        check_value("extra_writes", 32'd0, got_q.size());
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests = tests + 1;
        $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int         e;
        int         n;
        int         starts;
        logic       seen;
        logic [7:0] b;
        reset_dc_out = 1'b1;
        video_ready  = 1'b0;
        rdempty      = 1'b1;
        fdata        = 8'd0;
        cfg_ref      = 10'h002;
        for (int i = 0; i < 4; i++) begin
            last_w[i] = 24'd0;
        end

        //////////////////////////////
        // reset state and console release
        e = errors;
        repeat (10) @(posedge control_clock);
        #1;
        check_value("scl_oe", 32'd0, {31'd0, scl_oe});
        check_value("sda_oe", 32'd0, {31'd0, sda_oe});
        check_value("rdreq", 32'd0, {31'd0, rdreq});
        check_value("ready", 32'd0, {31'd0, ready});
        check_value("dc_nreset", 32'd0, {31'd0, dc_nreset});
        #1 reset_dc_out = 1'b0;
        n    = 0;
        seen = 1'b0;
        while (!seen && (n < 1000)) begin
            @(posedge control_clock);
            #1;
            n    = n + 1;
            seen = dc_nreset;
        end
        check_value("dc_nreset_delay", `DC_RESET_CYCLES + 32'd1, n);
        end_test("reset state", e);

        // video_ready alone holds back the first list
        e = errors;
        check_value("start_count", 32'd0, start_count);

        // second reset with video_ready high so only the startup delay gates
        #1;
        reset_dc_out = 1'b1;
        video_ready  = 1'b1;
        repeat (10) @(posedge control_clock);
        #2 reset_dc_out = 1'b0;
        n = 0;
        while ((start_count == 0) && (n < 2 * `HDMI_STARTUP_CYCLES)) begin
            @(negedge control_clock);
            n = n + 1;
        end
        if (start_count == 0) begin
            errors = errors + 1;
            $display("timeout: no START after the startup delay with video_ready high");
        end else if (n <= `HDMI_STARTUP_CYCLES) begin
            errors = errors + 1;
            $display("START came %0d cycles after reset, before the startup delay ended", n);
        end
        end_test("start gating", e);

        e = errors;
        expect_list(cfg_ref);
        wait_ready("default list");
        check_value("writes_before_ready", 32'd0, exp_q.size());
        wait_drained("default list");
        end_test("default programming", e);

        e = errors;
        send_byte(8'h04);
        send_byte(8'h81);
        send_byte(8'h92);
        send_byte(8'hD3);
        send_byte(8'h81);
        send_byte(8'h04);
        end_test("decoding", e);

        // refuse the register byte of the third write once
        e = errors;
        starts     = start_count;
        nack_byte  = 1;
        nack_start = start_count + 3;
        nack_arm   = 1'b1;
        cfg_ref    = apply_byte(cfg_ref, 8'h05);
        exp_q.push_back(ref_write(cfg_ref, 0));
        exp_q.push_back(ref_write(cfg_ref, 1));
        expect_list(cfg_ref);
        fifo_q.push_back(8'h05);
        settle(6);
        check_value("ready", 32'd0, {31'd0, ready});
        wait_ready("nack recovery");
        check_value("writes_before_ready", 32'd0, exp_q.size());
        wait_drained("nack recovery");
        settle(20);
        check_value("nack_used", 32'd0, {31'd0, nack_arm});
        check_value("start_count", 32'd7, start_count - starts);
        check_value("extra_writes", 32'd0, got_q.size());
        end_test("nack recovery", e);

        //////////////////////////////
        // random streams
        e = errors;
        compare_en = 1'b0;
        for (int round = 0; round < 3; round++) begin
            for (int i = 0; i < 10; i++) begin
                random_byte(b);
                cfg_ref = apply_byte(cfg_ref, b);
                fifo_q.push_back(b);
            end
            wait_drained("random stream");
            settle(6);
            wait_ready("random stream");
            for (int i = 0; i < 4; i++) begin
                check_value("last_list", {8'd0, ref_write(cfg_ref, i)}, {8'd0, last_w[i]});
            end
            got_q.delete();
        end
        end_test("random streams", e);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/hdmi_ctrl_top.sv ====
`timescale 1ns/100ps

module hdmi_ctrl_top import hdmi_ctrl_pkg::*; (
    input  logic       control_clock,
    input  logic       reset_dc_out,
    input  logic       video_ready,
    input  logic       rdempty,
    input  logic [7:0] fdata,
    output logic       rdreq,
    output logic       scl_oe,
    output logic       sda_oe,
    input  logic       sda_in,
    output logic       ready,
    output logic       dc_nreset
);

    adv_config_t adv_config;
    logic        config_changed;
    logic        startup_done;

    i2c_write_if i2c_bus ();

    //////////////////////////////
    // transmitter programming
    startup_delay startup_delay_inst (
        .control_clock (control_clock),
        .reset_dc_out  (reset_dc_out),
        .done          (startup_done)
    );

    reconf_decoder reconf_decoder_inst (
        .control_clock  (control_clock),
        .reset_dc_out   (reset_dc_out),
        .rdempty        (rdempty),
        .fdata          (fdata),
        .rdreq          (rdreq),
        .adv_config     (adv_config),
        .config_changed (config_changed)
    );

    adv_register_sequencer adv_register_sequencer_inst (
        .control_clock  (control_clock),
        .reset_dc_out   (reset_dc_out),
        .startup_done   (startup_done),
        .video_ready    (video_ready),
        .adv_config     (adv_config),
        .config_changed (config_changed),
        .bus            (i2c_bus.sequencer),
        .ready          (ready)
    );

    i2c_write_master i2c_write_master_inst (
        .control_clock (control_clock),
        .reset_dc_out  (reset_dc_out),
        .bus           (i2c_bus.master),
        .scl_oe        (scl_oe),
        .sda_oe        (sda_oe),
        .sda_in        (sda_in)
    );

    //////////////////////////////
    // console reset
    dc_reset_hold dc_reset_hold_inst (
        .control_clock (control_clock),
        .reset_dc_out  (reset_dc_out),
        .dc_nreset     (dc_nreset)
    );

endmodule

// ==== rtl/dc_reset_hold.sv ====
`timescale 1ns/100ps
`include "hdmi_ctrl_cfg.svh"

module dc_reset_hold (
    input  logic control_clock,
    input  logic reset_dc_out,
    output logic dc_nreset
);

    logic [31:0] count;

    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            count     <= 32'd0;
            dc_nreset <= 1'b0;
        end else if (count == `DC_RESET_CYCLES) begin
            // hold time reached, let the console run
            dc_nreset <= 1'b1;
        end else begin
            count <= count + 32'd1;
        end
    end

endmodule

// ==== rtl/i2c_write_master.sv ====
`timescale 1ns/100ps
`include "hdmi_ctrl_cfg.svh"

module i2c_write_master (
    input  logic        control_clock,
    input  logic        reset_dc_out,
    i2c_write_if.master bus,
    output logic        scl_oe,
    output logic        sda_oe,
    input  logic        sda_in
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_BIT   = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

    logic [1:0]  state;
    logic [7:0]  qcount;
    logic [1:0]  quarter;
    // 0..7 data, 8 is the acknowledge slot
    logic [3:0]  bit_index;
    logic [1:0]  byte_index;
    logic [23:0] shift;
    logic        tick;
    logic        phase_end;
    logic        ack_slot;

    assign tick      = (qcount == `I2C_QUARTER_CYCLES - 8'd1);
    assign phase_end = tick && (quarter == 2'd3);
    assign ack_slot  = (bit_index == 4'd8);

    //////////////////////////////
    // bit timing and sequencing
    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            state      <= ST_IDLE;
            qcount     <= 8'd0;
            quarter    <= 2'd0;
            bit_index  <= 4'd0;
            byte_index <= 2'd0;
            bus.busy   <= 1'b0;
            bus.done   <= 1'b0;
            bus.nack   <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (state == ST_IDLE) begin
                qcount  <= 8'd0;
                quarter <= 2'd0;
                if (bus.start) begin
                    shift      <= {bus.dev_addr, bus.reg_addr, bus.data};
                    bus.busy   <= 1'b1;
                    bus.nack   <= 1'b0;
                    bit_index  <= 4'd0;
                    byte_index <= 2'd0;
                    state      <= ST_START;
                end
            end else begin
                qcount <= tick ? 8'd0 : qcount + 8'd1;
                if (tick) begin
                    quarter <= quarter + 2'd1;
                end
                // middle of scl high
                if ((state == ST_BIT) && ack_slot && tick && (quarter == 2'd1)) begin
                    bus.nack <= sda_in;
                end
                if (phase_end) begin
                    case (state)
                        ST_START: state <= ST_BIT;
                        ST_BIT: begin
                            if (ack_slot) begin
                                bit_index <= 4'd0;
                                // give up on the first refused byte
                                if (bus.nack || (byte_index == 2'd2)) begin
                                    state <= ST_STOP;
                                end else begin
                                    byte_index <= byte_index + 2'd1;
                                end
                            end else begin
                                bit_index <= bit_index + 4'd1;
                                shift     <= {shift[22:0], 1'b0};
                            end
                        end
                        default: begin
                            state    <= ST_IDLE;
                            bus.busy <= 1'b0;
                            bus.done <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

    //////////////////////////////
    // open-drain line levels
    always_comb begin
        scl_oe = 1'b0;
        sda_oe = 1'b0;
        case (state)
            ST_START: begin
                sda_oe = (quarter != 2'd0);
                scl_oe = (quarter == 2'd3);
            end
            ST_BIT: begin
                scl_oe = (quarter == 2'd0) || (quarter == 2'd3);
                sda_oe = !ack_slot && !shift[23];
            end
            ST_STOP: begin
                scl_oe = (quarter == 2'd0);
                sda_oe = !quarter[1];
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/adv_register_sequencer.sv ====
`timescale 1ns/100ps
`include "hdmi_ctrl_cfg.svh"

module adv_register_sequencer import hdmi_ctrl_pkg::*; (
    input  logic          control_clock,
    input  logic          reset_dc_out,
    input  logic          startup_done,
    input  logic          video_ready,
    input  adv_config_t   adv_config,
    input  logic          config_changed,
    i2c_write_if.sequencer bus,
    output logic          ready
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_BUSY  = 2'd2;
    localparam logic [1:0] S_READY = 2'd3;

    logic [1:0]  state;
    logic [1:0]  reg_index;
    adv_config_t sampled;
    logic        pending;
    logic        rewrite_due;
    logic        new_list;

    assign rewrite_due = pending || config_changed;

    // restart from the power write, sampling the current config
    assign new_list = ((state == S_IDLE) && startup_done && video_ready)
                   || ((state == S_BUSY) && bus.done && (bus.nack || rewrite_due))
                   || ((state == S_READY) && rewrite_due);

    assign bus.dev_addr = `ADV_DEV_ADDR;

    // register list
    always_comb begin
        case (reg_index)
            2'd0: begin
                bus.reg_addr = `ADV_REG_POWER;
                bus.data     = `ADV_POWER_UP_VALUE;
            end
            2'd1: begin
                bus.reg_addr = `ADV_REG_CSC;
                bus.data     = {7'd0, sampled.color_space};
            end
            2'd2: begin
                bus.reg_addr = `ADV_REG_REPEAT;
                bus.data     = {6'd0, sampled.pixel_repeat};
            end
            default: begin
                bus.reg_addr = `ADV_REG_VIC;
                bus.data     = {1'b0, sampled.vic};
            end
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            state     <= S_IDLE;
            reg_index <= 2'd0;
            pending   <= 1'b0;
            ready     <= 1'b0;
            bus.start <= 1'b0;
        end else begin
            bus.start <= 1'b0;
            if (config_changed) begin
                pending <= 1'b1;
                ready   <= 1'b0;
            end
            if (new_list) begin
                sampled   <= adv_config;
                reg_index <= 2'd0;
                pending   <= 1'b0;
                state     <= S_START;
            end else begin
                case (state)
                    S_START: begin
                        if (!bus.busy) begin
                            bus.start <= 1'b1;
                            state     <= S_BUSY;
                        end
                    end
                    S_BUSY: begin
                        if (bus.done && (reg_index == 2'd3)) begin
                            ready <= 1'b1;
                            state <= S_READY;
                        end else if (bus.done) begin
                            reg_index <= reg_index + 2'd1;
                            state     <= S_START;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== rtl/reconf_decoder.sv ====
`timescale 1ns/100ps

module reconf_decoder import hdmi_ctrl_pkg::*; (
    input  logic        control_clock,
    input  logic        reset_dc_out,
    input  logic        rdempty,
    input  logic [7:0]  fdata,
    output logic        rdreq,
    output adv_config_t adv_config,
    output logic        config_changed
);

    reconf_byte_u fdata_view;
    adv_config_t  next_config;
    // fifo word is on fdata this cycle
    logic         fdata_valid;

    assign fdata_view = fdata;

    always_comb begin
        next_config = adv_config;
        if (!fdata_view.mode.is_setting) begin
            next_config.vic = fdata_view.mode.vic;
        end else begin
            case (fdata_view.setting.field)
                FIELD_COLOR_SPACE:  next_config.color_space = fdata_view.setting.value[0];
                FIELD_PIXEL_REPEAT: next_config.pixel_repeat = fdata_view.setting.value[1:0];
                // unknown field numbers leave the config alone
                default: ;
            endcase
        end
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            rdreq          <= 1'b0;
            fdata_valid    <= 1'b0;
            adv_config     <= ADV_CONFIG_DEFAULT;
            config_changed <= 1'b0;
        end else begin
            // rdempty is stale while a request is out, so skip a cycle
            rdreq          <= !rdempty && !rdreq;
            fdata_valid    <= rdreq;
            config_changed <= fdata_valid && (next_config != adv_config);
            if (fdata_valid) begin
                adv_config <= next_config;
            end
        end
    end

endmodule

// ==== rtl/startup_delay.sv ====
`timescale 1ns/100ps
`include "hdmi_ctrl_cfg.svh"

module startup_delay (
    input  logic control_clock,
    input  logic reset_dc_out,
    output logic done
);

    // cycles left before the transmitter may be touched
    logic [31:0] remaining;

    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            remaining <= `HDMI_STARTUP_CYCLES;
            done      <= 1'b0;
        end else begin
            if (remaining != 32'd0) begin
                remaining <= remaining - 32'd1;
            end else begin
                // stays set until the next reset
                done <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/i2c_write_if.sv ====
`timescale 1ns/100ps

interface i2c_write_if;

    logic       start;
    logic       busy;
    logic [7:0] dev_addr;
    logic [7:0] reg_addr;
    logic [7:0] data;
    logic       done;
    logic       nack;

    // request side, one register write at a time
    modport sequencer (
        output start, dev_addr, reg_addr, data,
        input  busy, done, nack
    );

    modport master (
        input  start, dev_addr, reg_addr, data,
        output busy, done, nack
    );

endinterface

// ==== rtl/hdmi_ctrl_pkg.sv ====
package hdmi_ctrl_pkg;

    // transmitter configuration as held by the decoder
    typedef struct packed {
        logic       color_space;
        logic [1:0] pixel_repeat;
        logic [6:0] vic;
    } adv_config_t;

    // rgb, no repeat, vic 2
    localparam adv_config_t ADV_CONFIG_DEFAULT = '{
        color_space:  1'b0,
        pixel_repeat: 2'd0,
        vic:          7'd2
    };

    // bit 7 clear, new video mode
    typedef struct packed {
        logic       is_setting;
        logic [6:0] vic;
    } reconf_mode_t;

    // bit 7 set, one field update
    typedef struct packed {
        logic       is_setting;
        logic [2:0] field;
        logic [3:0] value;
    } reconf_setting_t;

    typedef union packed {
        reconf_mode_t    mode;
        reconf_setting_t setting;
    } reconf_byte_u;

    typedef enum logic [2:0] {
        FIELD_COLOR_SPACE  = 3'd0,
        FIELD_PIXEL_REPEAT = 3'd1
    } reconf_field_e;

endpackage

// ==== rtl/hdmi_ctrl_cfg.svh ====
`ifndef HDMI_CTRL_CFG_SVH
`define HDMI_CTRL_CFG_SVH

// power-up wait before the transmitter may be programmed, short for simulation
`define HDMI_STARTUP_CYCLES 32'd200
// console reset hold after a reset request
`define DC_RESET_CYCLES 32'd500
// control clocks per quarter of one scl bit
`define I2C_QUARTER_CYCLES 8'd4

// transmitter write address and register map
`define ADV_DEV_ADDR 8'h72
`define ADV_REG_POWER 8'h41
`define ADV_REG_CSC 8'h15
`define ADV_REG_REPEAT 8'h3B
`define ADV_REG_VIC 8'h3C
`define ADV_POWER_UP_VALUE 8'h10

`endif
